//--- hdl/lsu_pkg.sv
// load/store subsystem constants
// bus widths, cache geometry and access size codes shared by all blocks
package lsu_pkg;

    // data and address buses
    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 12;             // 4 KiB of data RAM
    localparam int STRB_W    = DATA_W / 8;     // one apb strobe per byte lane
    localparam int OFFS_W    = 2;              // byte offset inside a word

    // RAM and cache geometry
    localparam int RAM_DEPTH   = 1024;         // words
    localparam int CACHE_LINES = 16;           // one word per line
    localparam int INDEX_W     = 4;            // word address bits [5:2]
    localparam int TAG_W       = 6;            // address bits [11:6]

    // access size codes on size_i
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

endpackage : lsu_pkg

//--- hdl/lsu_core.sv
`timescale 1ns/1ps
// load/store unit
// checks alignment, steers store lanes and strobes, serves load hits from
// the data cache and runs one apb transfer for each miss or store
module lsu_core
    import lsu_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,
    input  logic                req_i,
    input  logic [ADDR_W-1:0]   addr_i,
    input  logic [DATA_W-1:0]   wdata_i,
    input  logic                we_i,
    input  logic [1:0]          size_i,
    input  logic                sign_i,
    input  logic                hit_i,
    input  logic [DATA_W-1:0]   cache_rdata_i,
    input  logic                pready_i,
    input  logic [DATA_W-1:0]   prdata_i,
    output logic                busy_o,
    output logic                done_o,
    output logic                err_o,
    output logic [DATA_W-1:0]   rdata_o,
    output logic                psel_o,
    output logic                penable_o,
    output logic                pwrite_o,
    output logic [ADDR_W-1:0]   paddr_o,
    output logic [DATA_W-1:0]   pwdata_o,
    output logic [STRB_W-1:0]   pstrb_o,
    output logic                refill_o,
    output logic                store_o
);

    typedef enum logic [1:0] { ST_IDLE, ST_SETUP, ST_ACCESS } state_t;

    state_t                 state;
    logic                   misaligned;
    logic                   accept;
    logic                   hit_load;
    logic                   xfer_done;
    logic [DATA_W-1:0]      lane_data;
    logic [STRB_W-1:0]      lane_strb;
    logic [ADDR_W-1:0]      addr_q;
    logic [DATA_W-1:0]      data_q;     // store lanes, later the refill word
    logic [STRB_W-1:0]      strb_q;
    logic                   we_q;
    logic [1:0]             size_q;
    logic                   sign_q;
    logic                   refill_q;
    logic                   store_q;

    // pick the addressed byte or halfword and extend it
    function automatic logic [DATA_W-1:0] extend
    (
        input logic [DATA_W-1:0] data,
        input logic [OFFS_W-1:0] offs,
        input logic [1:0]        size,
        input logic              sgn
    );
        logic [7:0]  b;
        logic [15:0] h;
        b = data[{offs, 3'b000} +: 8];
        h = offs[1] ? data[DATA_W-1 -: 16] : data[15:0];
        case (size)
            SIZE_BYTE: extend = {{(DATA_W-8){sgn & b[7]}}, b};
            SIZE_HALF: extend = {{(DATA_W-16){sgn & h[15]}}, h};
            default:   extend = data;
        endcase
    endfunction

    always_comb
    begin
        case (size_i)
            SIZE_HALF: misaligned = addr_i[0];
            SIZE_WORD: misaligned = |addr_i[OFFS_W-1:0];
            default:   misaligned = 1'b0;
        endcase
    end

    // replicate the store value and mark the lanes it covers
    always_comb
    begin
        case (size_i)
            SIZE_BYTE:
            begin
                lane_data = {STRB_W{wdata_i[7:0]}};
                lane_strb = STRB_W'(1) << addr_i[OFFS_W-1:0];
            end
            SIZE_HALF:
            begin
                lane_data = {(STRB_W/2){wdata_i[15:0]}};
                lane_strb = STRB_W'(3) << {addr_i[1], 1'b0};
            end
            default:
            begin
                lane_data = wdata_i;
                lane_strb = '1;
            end
        endcase
    end

    assign busy_o    = (state != ST_IDLE);
    assign err_o     = req_i && !busy_o && misaligned;      // same cycle, no transfer
    assign accept    = req_i && !busy_o && !done_o && !misaligned;  // gap after done
    assign hit_load  = accept && !we_i && hit_i;
    assign xfer_done = (state == ST_ACCESS) && pready_i;

    assign psel_o    = busy_o;
    assign penable_o = (state == ST_ACCESS);
    assign pwrite_o  = we_q;
    assign paddr_o   = addr_q;
    assign pwdata_o  = data_q;
    assign pstrb_o   = strb_q;
    assign refill_o  = refill_q;
    assign store_o   = store_q;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state    <= ST_IDLE;
            done_o   <= 1'b0;
            refill_q <= 1'b0;
            store_q  <= 1'b0;
        end
        else
        begin
            done_o   <= hit_load || xfer_done;
            refill_q <= xfer_done && !we_q;     // cache update in the done cycle
            store_q  <= xfer_done && we_q;
            case (state)
                ST_IDLE:
                    if (accept && !hit_load)
                        state <= ST_SETUP;
                ST_SETUP:
                    state <= ST_ACCESS;
                ST_ACCESS:
                    if (pready_i)
                        state <= ST_IDLE;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            addr_q <= addr_i;
            data_q <= lane_data;
            strb_q <= lane_strb;
            we_q   <= we_i;
            size_q <= size_i;
            sign_q <= sign_i;
        end
        else if (xfer_done && !we_q)
            data_q <= prdata_i;                 // full word for the line refill
        if (hit_load)
            rdata_o <= extend(cache_rdata_i, addr_i[OFFS_W-1:0], size_i, sign_i);
        else if (xfer_done && !we_q)
            rdata_o <= extend(prdata_i, addr_q[OFFS_W-1:0], size_q, sign_q);
    end

endmodule : lsu_core

//--- hdl/dcache.sv
`timescale 1ns/1ps
// direct-mapped write-through data cache, one word per line
// combinational lookup, refill on load miss, store update on tag hit
// and invalidate from debug writes
module dcache
    import lsu_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,
    input  logic [ADDR_W-1:0]   lookup_addr_i,
    input  logic [ADDR_W-1:0]   upd_addr_i,
    input  logic [DATA_W-1:0]   upd_data_i,
    input  logic [STRB_W-1:0]   upd_strb_i,
    input  logic                refill_i,
    input  logic                store_i,
    input  logic                inv_i,
    input  logic [ADDR_W-1:0]   inv_addr_i,
    output logic                hit_o,
    output logic [DATA_W-1:0]   rdata_o
);

    logic [CACHE_LINES-1:0] valid;
    logic [TAG_W-1:0]       tag_mem  [CACHE_LINES];
    logic [DATA_W-1:0]      data_mem [CACHE_LINES];
    logic [INDEX_W-1:0]     lk_idx;
    logic [INDEX_W-1:0]     upd_idx;
    logic [INDEX_W-1:0]     inv_idx;
    logic [TAG_W-1:0]       lk_tag;
    logic [TAG_W-1:0]       upd_tag;
    logic [TAG_W-1:0]       inv_tag;
    logic                   upd_hit;
    logic                   inv_hit;

    assign lk_idx  = lookup_addr_i[OFFS_W +: INDEX_W];
    assign lk_tag  = lookup_addr_i[ADDR_W-1 -: TAG_W];
    assign upd_idx = upd_addr_i[OFFS_W +: INDEX_W];
    assign upd_tag = upd_addr_i[ADDR_W-1 -: TAG_W];
    assign inv_idx = inv_addr_i[OFFS_W +: INDEX_W];
    assign inv_tag = inv_addr_i[ADDR_W-1 -: TAG_W];

    assign hit_o   = valid[lk_idx] && (tag_mem[lk_idx] == lk_tag);
    assign rdata_o = data_mem[lk_idx];
    assign upd_hit = valid[upd_idx] && (tag_mem[upd_idx] == upd_tag);
    // a refill landing on the same line is dropped too
    assign inv_hit = inv_i && ((tag_mem[inv_idx] == inv_tag) ||
                               (refill_i && (upd_idx == inv_idx)));

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            valid <= '0;
        else
        begin
            if (refill_i)
                valid[upd_idx] <= 1'b1;
            if (inv_hit)
                valid[inv_idx] <= 1'b0;         // invalidate wins
        end
    end

    always_ff @(posedge clk)
    begin
        if (refill_i)
        begin
            tag_mem[upd_idx]  <= upd_tag;
            data_mem[upd_idx] <= upd_data_i;
        end
        else if (store_i && upd_hit)
        begin
            for (int k = 0; k < STRB_W; k++)
                if (upd_strb_i[k])
                    data_mem[upd_idx][8*k +: 8] <= upd_data_i[8*k +: 8];
        end
    end

endmodule : dcache

//--- hdl/apb_arbiter.sv
`timescale 1ns/1ps
// two-master apb arbiter, load/store unit over debug port
// grant is picked while idle and held through setup and access,
// debug writes are flagged to the cache for invalidation
module apb_arbiter
    import lsu_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,
    input  logic                m0_psel_i,
    input  logic                m0_penable_i,
    input  logic                m0_pwrite_i,
    input  logic [ADDR_W-1:0]   m0_paddr_i,
    input  logic [DATA_W-1:0]   m0_pwdata_i,
    input  logic [STRB_W-1:0]   m0_pstrb_i,
    output logic                m0_pready_o,
    output logic [DATA_W-1:0]   m0_prdata_o,
    input  logic                m1_psel_i,
    input  logic                m1_penable_i,
    input  logic                m1_pwrite_i,
    input  logic [ADDR_W-1:0]   m1_paddr_i,
    input  logic [DATA_W-1:0]   m1_pwdata_i,
    input  logic [STRB_W-1:0]   m1_pstrb_i,
    output logic                m1_pready_o,
    output logic [DATA_W-1:0]   m1_prdata_o,
    output logic                s_psel_o,
    output logic                s_penable_o,
    output logic                s_pwrite_o,
    output logic [ADDR_W-1:0]   s_paddr_o,
    output logic [DATA_W-1:0]   s_pwdata_o,
    output logic [STRB_W-1:0]   s_pstrb_o,
    input  logic                s_pready_i,
    input  logic [DATA_W-1:0]   s_prdata_i,
    output logic                inv_o,
    output logic [ADDR_W-1:0]   inv_addr_o
);

    logic   active_q;       // slave in access phase
    logic   gnt_q;          // 1 = debug port
    logic   gnt;
    logic   xfer_done;

    // fixed priority while idle, held grant otherwise
    assign gnt = active_q ? gnt_q : !m0_psel_i;

    assign s_psel_o    = active_q || m0_psel_i || m1_psel_i;  // setup from idle
    assign s_penable_o = active_q;
    assign s_pwrite_o  = gnt ? m1_pwrite_i : m0_pwrite_i;
    assign s_paddr_o   = gnt ? m1_paddr_i  : m0_paddr_i;
    assign s_pwdata_o  = gnt ? m1_pwdata_i : m0_pwdata_i;
    assign s_pstrb_o   = gnt ? m1_pstrb_i  : m0_pstrb_i;

    // granted master must already sit in its own access phase
    assign xfer_done = active_q && s_pready_i && (gnt_q ? m1_penable_i : m0_penable_i);

    assign m0_pready_o = xfer_done && !gnt_q;
    assign m1_pready_o = xfer_done && gnt_q;
    assign m0_prdata_o = s_prdata_i;
    assign m1_prdata_o = s_prdata_i;

    assign inv_o      = active_q && gnt_q && m1_pwrite_i;
    assign inv_addr_o = m1_paddr_i;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            active_q <= 1'b0;
            gnt_q    <= 1'b0;
        end
        else if (!active_q && s_psel_o)
        begin
            active_q <= 1'b1;
            gnt_q    <= gnt;
        end
        else if (xfer_done)
            active_q <= 1'b0;
    end

endmodule : apb_arbiter

//--- hdl/apb_ram.sv
`timescale 1ns/1ps
// word-wide apb data RAM with byte strobes
// zero wait states, read data valid during the access phase
module apb_ram
    import lsu_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  logic [ADDR_W-1:0]   paddr_i,
    input  logic [DATA_W-1:0]   pwdata_i,
    input  logic [STRB_W-1:0]   pstrb_i,
    output logic                pready_o,
    output logic [DATA_W-1:0]   prdata_o
);

    logic [DATA_W-1:0]          mem [RAM_DEPTH];
    logic [ADDR_W-OFFS_W-1:0]   widx;
    logic                       ready_q;
    logic                       access;

    assign widx     = paddr_i[ADDR_W-1:OFFS_W];
    assign access   = psel_i && penable_i;
    assign pready_o = ready_q;                  // set by every setup phase
    assign prdata_o = access ? mem[widx] : '0;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            ready_q <= 1'b0;
        else
            ready_q <= psel_i && !penable_i;
    end

    always_ff @(posedge clk)
    begin
        if (access && pwrite_i)
        begin
            for (int k = 0; k < STRB_W; k++)
                if (pstrb_i[k])
                    mem[widx][8*k +: 8] <= pwdata_i[8*k +: 8];
        end
    end

endmodule : apb_ram

//--- hdl/lsu_subsys.sv
`timescale 1ns/1ps
// load/store subsystem top level
// load/store unit and data cache share the data RAM with a debug apb port
module lsu_subsys
    import lsu_pkg::*;
(
    input  logic                clk,
    input  logic                resetn,
    input  logic                req_i,
    input  logic [ADDR_W-1:0]   addr_i,
    input  logic [DATA_W-1:0]   wdata_i,
    input  logic                we_i,
    input  logic [1:0]          size_i,
    input  logic                sign_i,
    output logic                busy_o,
    output logic                done_o,
    output logic                err_o,
    output logic [DATA_W-1:0]   rdata_o,
    input  logic                dbg_psel_i,
    input  logic                dbg_penable_i,
    input  logic                dbg_pwrite_i,
    input  logic [ADDR_W-1:0]   dbg_paddr_i,
    input  logic [DATA_W-1:0]   dbg_pwdata_i,
    input  logic [STRB_W-1:0]   dbg_pstrb_i,
    output logic                dbg_pready_o,
    output logic [DATA_W-1:0]   dbg_prdata_o
);

    logic                hit;
    logic [DATA_W-1:0]   cache_rdata;
    logic                refill;
    logic                store;
    logic                inv;
    logic [ADDR_W-1:0]   inv_addr;
    // load/store unit master side
    logic                lsu_psel;
    logic                lsu_penable;
    logic                lsu_pwrite;
    logic [ADDR_W-1:0]   lsu_paddr;
    logic [DATA_W-1:0]   lsu_pwdata;
    logic [STRB_W-1:0]   lsu_pstrb;
    logic                lsu_pready;
    logic [DATA_W-1:0]   lsu_prdata;
    // RAM side
    logic                ram_psel;
    logic                ram_penable;
    logic                ram_pwrite;
    logic [ADDR_W-1:0]   ram_paddr;
    logic [DATA_W-1:0]   ram_pwdata;
    logic [STRB_W-1:0]   ram_pstrb;
    logic                ram_pready;
    logic [DATA_W-1:0]   ram_prdata;

    lsu_core u_lsu_core
    (
        .clk            ( clk           ),
        .resetn         ( resetn        ),
        .req_i          ( req_i         ),
        .addr_i         ( addr_i        ),
        .wdata_i        ( wdata_i       ),
        .we_i           ( we_i          ),
        .size_i         ( size_i        ),
        .sign_i         ( sign_i        ),
        .hit_i          ( hit           ),
        .cache_rdata_i  ( cache_rdata   ),
        .pready_i       ( lsu_pready    ),
        .prdata_i       ( lsu_prdata    ),
        .busy_o         ( busy_o        ),
        .done_o         ( done_o        ),
        .err_o          ( err_o         ),
        .rdata_o        ( rdata_o       ),
        .psel_o         ( lsu_psel      ),
        .penable_o      ( lsu_penable   ),
        .pwrite_o       ( lsu_pwrite    ),
        .paddr_o        ( lsu_paddr     ),
        .pwdata_o       ( lsu_pwdata    ),
        .pstrb_o        ( lsu_pstrb     ),
        .refill_o       ( refill        ),
        .store_o        ( store         )
    );

    dcache u_dcache
    (
        .clk            ( clk           ),
        .resetn         ( resetn        ),
        .lookup_addr_i  ( addr_i        ),  // lookup straight from the pipeline
        .upd_addr_i     ( lsu_paddr     ),
        .upd_data_i     ( lsu_pwdata    ),
        .upd_strb_i     ( lsu_pstrb     ),
        .refill_i       ( refill        ),
        .store_i        ( store         ),
        .inv_i          ( inv           ),
        .inv_addr_i     ( inv_addr      ),
        .hit_o          ( hit           ),
        .rdata_o        ( cache_rdata   )
    );

    apb_arbiter u_apb_arbiter
    (
        .clk            ( clk           ),
        .resetn         ( resetn        ),
        .m0_psel_i      ( lsu_psel      ),
        .m0_penable_i   ( lsu_penable   ),
        .m0_pwrite_i    ( lsu_pwrite    ),
        .m0_paddr_i     ( lsu_paddr     ),
        .m0_pwdata_i    ( lsu_pwdata    ),
        .m0_pstrb_i     ( lsu_pstrb     ),
        .m0_pready_o    ( lsu_pready    ),
        .m0_prdata_o    ( lsu_prdata    ),
        .m1_psel_i      ( dbg_psel_i    ),
        .m1_penable_i   ( dbg_penable_i ),
        .m1_pwrite_i    ( dbg_pwrite_i  ),
        .m1_paddr_i     ( dbg_paddr_i   ),
        .m1_pwdata_i    ( dbg_pwdata_i  ),
        .m1_pstrb_i     ( dbg_pstrb_i   ),
        .m1_pready_o    ( dbg_pready_o  ),
        .m1_prdata_o    ( dbg_prdata_o  ),
        .s_psel_o       ( ram_psel      ),
        .s_penable_o    ( ram_penable   ),
        .s_pwrite_o     ( ram_pwrite    ),
        .s_paddr_o      ( ram_paddr     ),
        .s_pwdata_o     ( ram_pwdata    ),
        .s_pstrb_o      ( ram_pstrb     ),
        .s_pready_i     ( ram_pready    ),
        .s_prdata_i     ( ram_prdata    ),
        .inv_o          ( inv           ),
        .inv_addr_o     ( inv_addr      )
    );

    apb_ram u_apb_ram
    (
        .clk            ( clk           ),
        .resetn         ( resetn        ),
        .psel_i         ( ram_psel      ),
        .penable_i      ( ram_penable   ),
        .pwrite_i       ( ram_pwrite    ),
        .paddr_i        ( ram_paddr     ),
        .pwdata_i       ( ram_pwdata    ),
        .pstrb_i        ( ram_pstrb     ),
        .pready_o       ( ram_pready    ),
        .prdata_o       ( ram_prdata    )
    );

endmodule : lsu_subsys

//--- verif/tb_clkgen.sv
`timescale 1ns/1ps
// testbench clock and reset generator
// 40 ns clock, active-low reset held for the first 8 cycles
module tb_clkgen
(
    output logic clk,
    output logic resetn
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 8;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial
    begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 resetn = 1'b1;                       // release clear of the edge
    end

endmodule : tb_clkgen

//--- verif/tb_lsu_subsys.sv
`timescale 1ns/1ps
// testbench for the load/store subsystem
// drives pipeline requests and debug apb transfers against a byte-wide
// reference model of the data RAM, concurrent assertions check the results
module tb_lsu_subsys
    import lsu_pkg::*;
();

    localparam int MAX_CYCLES = 4000;           // well above the length of all tests

    logic                clk;
    logic                resetn;
    logic                req_i;
    logic [ADDR_W-1:0]   addr_i;
    logic [DATA_W-1:0]   wdata_i;
    logic                we_i;
    logic [1:0]          size_i;
    logic                sign_i;
    logic                busy_o;
    logic                done_o;
    logic                err_o;
    logic [DATA_W-1:0]   rdata_o;
    logic                dbg_psel_i;
    logic                dbg_penable_i;
    logic                dbg_pwrite_i;
    logic [ADDR_W-1:0]   dbg_paddr_i;
    logic [DATA_W-1:0]   dbg_pwdata_i;
    logic [STRB_W-1:0]   dbg_pstrb_i;
    logic                dbg_pready_o;
    logic [DATA_W-1:0]   dbg_prdata_o;

    logic [7:0]          ref_mem [1 << ADDR_W];
    logic                exp_load;
    logic                exp_hit;
    logic                exp_misalign;
    logic [DATA_W-1:0]   exp_rdata;
    logic [DATA_W-1:0]   dbg_exp;
    int                  seed = 90564;
    int                  cycle_cnt = 0;

    tb_clkgen u_tb_clkgen
    (
        .clk    ( clk    ),
        .resetn ( resetn )
    );

    lsu_subsys u_lsu_subsys
    (
        .clk            ( clk           ),
        .resetn         ( resetn        ),
        .req_i          ( req_i         ),
        .addr_i         ( addr_i        ),
        .wdata_i        ( wdata_i       ),
        .we_i           ( we_i          ),
        .size_i         ( size_i        ),
        .sign_i         ( sign_i        ),
        .busy_o         ( busy_o        ),
        .done_o         ( done_o        ),
        .err_o          ( err_o         ),
        .rdata_o        ( rdata_o       ),
        .dbg_psel_i     ( dbg_psel_i    ),
        .dbg_penable_i  ( dbg_penable_i ),
        .dbg_pwrite_i   ( dbg_pwrite_i  ),
        .dbg_paddr_i    ( dbg_paddr_i   ),
        .dbg_pwdata_i   ( dbg_pwdata_i  ),
        .dbg_pstrb_i    ( dbg_pstrb_i   ),
        .dbg_pready_o   ( dbg_pready_o  ),
        .dbg_prdata_o   ( dbg_prdata_o  )
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch
    (
        input string             sig,
        input logic [DATA_W-1:0] exp,
        input logic [DATA_W-1:0] act
    );
        abort_run($sformatf("Mismatch at %0t ns: %s expected %h actual %h",
                            $time, sig, exp, act));
    endtask

    function automatic logic is_misaligned(input logic [ADDR_W-1:0] addr,
                                           input logic [1:0] size);
        case (size)
            SIZE_HALF: return addr[0];
            SIZE_WORD: return addr[1] | addr[0];
            default:   return 1'b0;
        endcase
    endfunction

    // little-endian read of the model with sign or zero extension
    function automatic logic [DATA_W-1:0] ref_load(input logic [ADDR_W-1:0] addr,
                                                   input logic [1:0] size,
                                                   input logic sgn);
        logic [7:0] lo;
        logic [7:0] hi;
        lo = ref_mem[{addr[ADDR_W-1:1], 1'b0}];
        hi = ref_mem[{addr[ADDR_W-1:1], 1'b1}];
        case (size)
            SIZE_BYTE: return {{24{sgn & ref_mem[addr][7]}}, ref_mem[addr]};
            SIZE_HALF: return {{16{sgn & hi[7]}}, hi, lo};
            default:   return {ref_mem[{addr[ADDR_W-1:2], 2'd3}], ref_mem[{addr[ADDR_W-1:2], 2'd2}],
                               ref_mem[{addr[ADDR_W-1:2], 2'd1}], ref_mem[{addr[ADDR_W-1:2], 2'd0}]};
        endcase
    endfunction

    task automatic ref_store(input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data,
                             input logic [1:0] size);
        case (size)
            SIZE_BYTE:
                ref_mem[addr] = data[7:0];
            SIZE_HALF:
            begin
                ref_mem[{addr[ADDR_W-1:1], 1'b0}] = data[7:0];
                ref_mem[{addr[ADDR_W-1:1], 1'b1}] = data[15:8];
            end
            default:
                for (int k = 0; k < STRB_W; k++)
                    ref_mem[{addr[ADDR_W-1:2], 2'(k)}] = data[8*k +: 8];
        endcase
    endtask

    // one pipeline request, held until done or for a few cycles after err
    task automatic lsu_req
    (
        input logic [ADDR_W-1:0] addr,
        input logic [DATA_W-1:0] wdata,
        input logic              we,
        input logic [1:0]        size,
        input logic              sgn,
        input logic              want_hit
    );
        logic bad;
        bad          = is_misaligned(addr, size);
        exp_misalign = bad;
        exp_load     = !we && !bad;
        exp_hit      = want_hit && !we && !bad;
        exp_rdata    = ref_load(addr, size, sgn);
        req_i   = 1'b1;
        addr_i  = addr;
        wdata_i = wdata;
        we_i    = we;
        size_i  = size;
        sign_i  = sgn;
        if (bad)
        begin
            @(posedge clk);
            #2;
            req_i = 1'b0;
            repeat (3) @(posedge clk);          // nothing may start meanwhile
            #2;
        end
        else
        begin
            do
            begin
                @(posedge clk);
                #2;
            end
            while (!done_o);
            req_i = 1'b0;
            if (we)
                ref_store(addr, wdata, size);
            @(posedge clk);                     // expectations held past the done edge
            #2;
        end
        exp_misalign = 1'b0;
        exp_load     = 1'b0;
        exp_hit      = 1'b0;
    endtask

    task automatic apb_handshake(input logic [ADDR_W-1:0] addr);
        dbg_paddr_i   = addr;
        dbg_pstrb_i   = '1;
        dbg_psel_i    = 1'b1;
        dbg_penable_i = 1'b0;
        @(posedge clk);
        #2;
        dbg_penable_i = 1'b1;
        @(negedge clk);
        while (!dbg_pready_o)                   // held off while the lsu owns the bus
            @(negedge clk);
        @(posedge clk);
        #2;
        dbg_psel_i    = 1'b0;
        dbg_penable_i = 1'b0;
    endtask

    task automatic dbg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        ref_store(addr, data, SIZE_WORD);
        dbg_pwrite_i = 1'b1;
        dbg_pwdata_i = data;
        apb_handshake(addr);
    endtask

    task automatic dbg_read(input logic [ADDR_W-1:0] addr);
        dbg_exp      = ref_load(addr, SIZE_WORD, 1'b0);
        dbg_pwrite_i = 1'b0;
        apb_handshake(addr);
    endtask

    task automatic load_extension_test();
        logic [ADDR_W-1:0] base;
        logic [DATA_W-1:0] word;
        logic              first;
        for (int w = 0; w < 8; w++)
        begin
            base = 12'h100 + 12'(4 * w);
            word = $random(seed);
            word = w[0] ? (word & 32'h7f7f_7f7f) : (word | 32'h8080_8080);
            dbg_write(base, word);
            first = 1'b1;
            for (int s = 0; s < 2; s++)
            begin
                for (int b = 0; b < 4; b++)
                begin
                    lsu_req(base + 12'(b), '0, 1'b0, SIZE_BYTE, s[0], !first);
                    first = 1'b0;
                end
                lsu_req(base, '0, 1'b0, SIZE_HALF, s[0], 1'b1);
                lsu_req(base + 12'd2, '0, 1'b0, SIZE_HALF, s[0], 1'b1);
            end
            lsu_req(base, '0, 1'b0, SIZE_WORD, 1'b0, 1'b1);
        end
    endtask

    task automatic store_lane_test();
        logic [ADDR_W-1:0] base;
        for (int w = 0; w < 4; w++)
        begin
            base = 12'h200 + 12'(4 * w);
            dbg_write(base, $random(seed));
            lsu_req(base, '0, 1'b0, SIZE_WORD, 1'b0, 1'b0);     // bring the line in
            for (int b = 0; b < 4; b++)
            begin
                lsu_req(base + 12'(b), $random(seed), 1'b1, SIZE_BYTE, 1'b0, 1'b0);
                dbg_read(base);
            end
            for (int h = 0; h < 4; h += 2)
            begin
                lsu_req(base + 12'(h), $random(seed), 1'b1, SIZE_HALF, 1'b0, 1'b0);
                dbg_read(base);
            end
            lsu_req(base, '0, 1'b0, SIZE_WORD, 1'b0, 1'b1);     // merged line still hits
            lsu_req(base + 12'd3, '0, 1'b0, SIZE_BYTE, 1'b1, 1'b1);
            lsu_req(base, $random(seed), 1'b1, SIZE_WORD, 1'b0, 1'b0);
            dbg_read(base);
        end
    endtask

    task automatic misalign_test();
        logic [ADDR_W-1:0] base;
        base = 12'h300;
        dbg_write(base, $random(seed));
        for (int off = 1; off < 4; off++)
        begin
            lsu_req(base + 12'(off), $random(seed), 1'b1, SIZE_WORD, 1'b0, 1'b0);
            lsu_req(base + 12'(off), '0, 1'b0, SIZE_WORD, 1'b1, 1'b0);
            if (off[0])
            begin
                lsu_req(base + 12'(off), $random(seed), 1'b1, SIZE_HALF, 1'b0, 1'b0);
                lsu_req(base + 12'(off), '0, 1'b0, SIZE_HALF, 1'b1, 1'b0);
            end
        end
        dbg_read(base);
    endtask

    task automatic hit_invalidate_test();
        logic [ADDR_W-1:0] addr;
        addr = 12'h344;
        dbg_write(addr, $random(seed));
        lsu_req(addr, '0, 1'b0, SIZE_WORD, 1'b0, 1'b0);         // miss and refill
        lsu_req(addr, '0, 1'b0, SIZE_WORD, 1'b0, 1'b1);
        lsu_req(addr + 12'd1, '0, 1'b0, SIZE_BYTE, 1'b1, 1'b1);
        dbg_write(addr, $random(seed));
        lsu_req(addr, '0, 1'b0, SIZE_WORD, 1'b0, 1'b0);         // must see the new word
        lsu_req(addr, '0, 1'b0, SIZE_HALF, 1'b1, 1'b1);
    endtask

    // lsu and debug traffic at once, in separate address regions
    task automatic contention_test();
        fork
            begin
                logic [ADDR_W-1:0] addr;
                logic [1:0]        size;
                for (int n = 0; n < 40; n++)
                begin
                    addr = 12'h100 | (12'($random(seed)) & 12'h01f);
                    size = 2'($unsigned($random(seed)) % 3);
                    lsu_req(addr, $random(seed), 1'($random(seed)), size,
                            1'($random(seed)), 1'b0);
                end
            end
            begin
                logic [ADDR_W-1:0] addr;
                for (int n = 0; n < 20; n++)
                begin
                    addr = 12'h800 | (12'($random(seed)) & 12'h03c);
                    dbg_write(addr, $random(seed));
                    dbg_read(addr);
                end
            end
        join
    endtask

    load_data_check: assert property (@(posedge clk) disable iff (!resetn)
        (done_o && exp_load) |-> (rdata_o == exp_rdata))
    else
        report_mismatch("rdata_o", $sampled(exp_rdata), $sampled(rdata_o));

    hit_latency_check: assert property (@(posedge clk) disable iff (!resetn)
        (req_i && exp_hit) |=> (done_o && !busy_o))
    else
        abort_run($sformatf("load hit at %0t ns did not finish one cycle after it was taken",
                            $time));

    err_check: assert property (@(posedge clk) disable iff (!resetn)
        err_o == (req_i && exp_misalign))
    else
        report_mismatch("err_o", 32'($sampled(req_i && exp_misalign)),
                        32'($sampled(err_o)));

    err_quiet_check: assert property (@(posedge clk) disable iff (!resetn)
        exp_misalign |-> (!done_o && !busy_o))
    else
        abort_run("a misaligned request started a transfer or raised done_o");

    dbg_read_check: assert property (@(posedge clk) disable iff (!resetn)
        (dbg_psel_i && dbg_penable_i && !dbg_pwrite_i && dbg_pready_o)
            |-> (dbg_prdata_o == dbg_exp))
    else
        report_mismatch("dbg_prdata_o", $sampled(dbg_exp), $sampled(dbg_prdata_o));

    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES)
            abort_run($sformatf("timeout after %0d cycles, a transfer never completed",
                                MAX_CYCLES));
    end

    initial
    begin
        req_i         = 1'b0;
        addr_i        = '0;
        wdata_i       = '0;
        we_i          = 1'b0;
        size_i        = SIZE_BYTE;
        sign_i        = 1'b0;
        dbg_psel_i    = 1'b0;
        dbg_penable_i = 1'b0;
        dbg_pwrite_i  = 1'b0;
        dbg_paddr_i   = '0;
        dbg_pwdata_i  = '0;
        dbg_pstrb_i   = '0;
        exp_load      = 1'b0;
        exp_hit       = 1'b0;
        exp_misalign  = 1'b0;
        exp_rdata     = '0;
        dbg_exp       = '0;
        wait (resetn === 1'b1);
        @(posedge clk);
        #2;
        load_extension_test();
        store_lane_test();
        misalign_test();
        hit_invalidate_test();
        contention_test();
        repeat (4) @(posedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule : tb_lsu_subsys

//--- lsu_subsys.f
hdl/lsu_pkg.sv
hdl/lsu_core.sv
hdl/dcache.sv
hdl/apb_arbiter.sv
hdl/apb_ram.sv
hdl/lsu_subsys.sv
verif/tb_clkgen.sv
verif/tb_lsu_subsys.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the lsu_subsys testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_lsu_subsys -f lsu_subsys.f -o sim_lsu_subsys; then
    echo "verilator build failed"
    exit 1
fi

if ! output="$(./obj_dir/sim_lsu_subsys)"; then
    echo "$output"
    echo "simulation run returned an error status"
    exit 1
fi
echo "$output"

if echo "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
echo "pass line not found in the simulation output"
exit 1
